//--- Makefile
# Verilator build and run for the IMU SPI reader

VERILATOR ?= verilator
TOP       ?= tb_imu_spi
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/imu_model.sv
`timescale 1ns/1ps

module imu_model (
    input  imu_host_pkg::spi_pins_t spi_pins,
    output logic                    miso
);

    logic                    scl;       // serial clock from the dut
    logic                    sda;       // frame select from the dut
    imu_link_pkg::spi_word_t in_sr;     // command bits taken so far
    imu_link_pkg::spi_word_t out_sr;    // reply bits still to send
    imu_link_pkg::spi_word_t reply;     // answer to the last full command
    imu_link_pkg::spi_word_t cmd_word;  // command including the current bit
    logic [4:0]              bit_cnt;   // bits of the current word

    assign scl = spi_pins.scl;
    assign sda = spi_pins.sda;

    initial begin
        miso    = 1'b0;
        in_sr   = '0;
        out_sr  = '0;
        reply   = '0;
        bit_cnt = '0;
    end

    // command bits on scl rise, a low sda starts a new frame
    always @(posedge scl or negedge sda) begin
        if (!sda) begin
            bit_cnt <= '0;
        end else begin
            cmd_word = {in_sr[14:0], spi_pins.mosi};
            in_sr <= cmd_word;
            if (bit_cnt == 5'd15) begin
                reply   <= {cmd_word[14:9], ~cmd_word[14:9], 4'h5};  // reg, inverse, 5
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 5'd1;
            end
        end
    end

    // reply bits change on scl fall, msb first, one word late
    always @(negedge scl) begin
        if (bit_cnt == 5'd0) begin
            miso   <= reply[15];
            out_sr <= {reply[14:0], 1'b0};
        end else begin
            miso   <= out_sr[15];
            out_sr <= {out_sr[14:0], 1'b0};
        end
    end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic xclk,
    output logic imu_ready_reset
);

    localparam int half_period = 5;     // 10 ns clock
    localparam int reset_cycles = 16;   // reset held for this many edges

    initial begin
        xclk = 1'b0;
        forever #(half_period) xclk = ~xclk;
    end

    initial begin
        imu_ready_reset = 1'b1;
        repeat (reset_cycles) @(posedge xclk);
        imu_ready_reset <= 1'b0;        // released on an edge like other inputs
    end

endmodule

//--- bench/tb_imu_spi.sv
`timescale 1ns/1ps

module tb_imu_spi;

    localparam int n_rows = 6;
    localparam int rises_per_sample = 16 * 29;  // 28 commands plus the flush word

    logic                    xclk;
    logic                    imu_ready_reset;
    imu_host_pkg::host_wr_t  host_wr;
    logic                    miso;
    logic                    rd_stb;
    imu_host_pkg::spi_pins_t spi_pins;
    logic                    ts;
    logic                    rdy;
    imu_link_pkg::spi_word_t rdata;

    // test name, half_bit, stall, period, samples to observe
    string names [n_rows] = '{"idle_reset", "single_fast", "single_slow",
                              "periodic_a", "periodic_b", "disable_mid"};
    int    hbs   [n_rows] = '{1, 1, 2, 1, 3, 1};
    int    stalls[n_rows] = '{0, 1, 4, 2, 0, 1};
    int    pers  [n_rows] = '{0, 1, 1, 2400, 4200, 3000};
    int    counts[n_rows] = '{0, 1, 1, 3, 2, 0};

    imu_link_pkg::reg_num_t exp_list [imu_link_pkg::list_depth];  // list now in the dut
    string cur_name;
    int    cyc = 0, limit = 0, ts_count = 0, sample_rises = 0, word_rises = 0;
    int    run_len = 0, mon_hb = 0, mon_st = 0, mon_err = 0, row_err = 0, n_fail = 0;
    logic  prev_scl = 1'b1, mon_on = 1'b0;

    tb_clock i_tb_clock (.xclk(xclk), .imu_ready_reset(imu_ready_reset));
    imu_model i_imu_model (.spi_pins(spi_pins), .miso(miso));

    imu_spi i_imu_spi (
        .xclk            (xclk),
        .imu_ready_reset (imu_ready_reset),
        .host_wr         (host_wr),
        .miso            (miso),
        .rd_stb          (rd_stb),
        .spi_pins        (spi_pins),
        .ts              (ts),
        .rdy             (rdy),
        .rdata           (rdata)
    );

    function automatic imu_link_pkg::spi_word_t reply_word(imu_link_pkg::reg_num_t r);
        return {r, ~r, 4'h5};
    endfunction

    function automatic int sample_len(int hb, int st);
        return (hb + 1) * (935 + 28 * st) + 16;     // prepare, 29 words, stalls, finish
    endfunction

    task automatic check_word(string what, imu_link_pkg::spi_word_t exp,
                              imu_link_pkg::spi_word_t act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %h, actual %h", cur_name, what, exp, act);
            row_err++;
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %b, actual %b", cur_name, what, exp, act);
            row_err++;
        end
    endtask

    task automatic check_count(string what, int exp, int act);
        if (exp != act) begin
            $display("Fail %s %s: expected %0d, actual %0d", cur_name, what, exp, act);
            row_err++;
        end
    endtask

    // scl shape checks and ts / rise counting, runs every cycle
    always @(posedge xclk) begin
        cyc <= cyc + 1;
        if (ts) begin
            ts_count++;
            sample_rises = 0;                   // rises are counted per sample
        end
        if (spi_pins.scl != prev_scl) begin
            if (mon_on && !prev_scl) begin      // rising edge ends a low half
                if (run_len != mon_hb + 1) begin
                    $display("Fail %s scl low time: expected %0d, actual %0d",
                             cur_name, mon_hb + 1, run_len);
                    mon_err++;
                end
                word_rises++;
                sample_rises++;
            end else if (mon_on) begin          // falling edge ends a high half
                if (word_rises == 16) begin     // gap between words
                    if (run_len < (mon_st + 1) * (mon_hb + 1)) begin
                        $display("Fail %s scl stall time: expected %0d, actual %0d",
                                 cur_name, (mon_st + 1) * (mon_hb + 1), run_len);
                        mon_err++;
                    end
                    word_rises = 0;
                end else if (word_rises != 0 && run_len != mon_hb + 1) begin
                    $display("Fail %s scl high time: expected %0d, actual %0d",
                             cur_name, mon_hb + 1, run_len);
                    mon_err++;
                end
            end
            run_len = 1;
        end else begin
            run_len++;
        end
        prev_scl = spi_pins.scl;
        if (!mon_on) word_rises = 0;
    end

    always @(posedge xclk) begin
        if (limit != 0 && cyc > limit) begin
            $display("timeout: the run went past %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic write_timing(int hb, int st);
        imu_host_pkg::host_wr_t w;
        w = '0;
        w.we_timing = 1'b1;
        w.data = {16'h0, 8'(st), 8'(hb)};       // stall in 15:8, half-bit in 7:0
        @(posedge xclk);
        host_wr <= w;
        @(posedge xclk);
        host_wr <= '0;
    endtask

    task automatic write_period(int p);
        imu_host_pkg::host_wr_t w;
        w = '0;
        w.we_period = 1'b1;
        w.data = 32'(p);
        @(posedge xclk);
        host_wr <= w;
        @(posedge xclk);
        host_wr <= '0;
    endtask

    task automatic load_list();
        imu_host_pkg::host_wr_t w;
        logic [31:0] val;
        for (int i = 0; i < imu_link_pkg::list_depth; i++) begin
            val = $urandom;
            exp_list[i] = val[5:0];
            w = '0;
            w.we_list = 1'b1;
            w.addr = 5'(i);
            w.data = val;                       // upper bits are don't care
            @(posedge xclk);
            host_wr <= w;
        end
        @(posedge xclk);
        host_wr <= '0;
    endtask

    // waits for ts, rdy must stay low meanwhile
    task automatic wait_ts(int max_cycles, output int t_ts, output bit ok);
        logic rdy_seen;
        rdy_seen = 1'b0;
        ok = 1'b0;
        t_ts = 0;
        for (int i = 0; i < max_cycles && !ok; i++) begin
            @(posedge xclk);
            if (rdy) rdy_seen = 1'b1;
            if (ts) begin
                ok = 1'b1;
                t_ts = cyc;
            end
        end
        check_flag("rdy before start", 1'b0, rdy_seen);
        if (!ok) begin
            $display("%s: no ts pulse came within %0d cycles", cur_name, max_cycles);
            row_err++;
        end
    endtask

    task automatic wait_rdy(int max_cycles, output bit ok);
        ok = 1'b0;
        for (int i = 0; i < max_cycles && !ok; i++) begin
            @(posedge xclk);
            if (rdy) ok = 1'b1;
        end
        if (!ok) begin
            $display("%s: rdy did not rise within %0d cycles", cur_name, max_cycles);
            row_err++;
        end
    endtask

    task automatic read_buffer();
        for (int j = 0; j < imu_link_pkg::words_per_sample; j++) begin
            @(posedge xclk);
            check_word($sformatf("word %0d", j), reply_word(exp_list[j]), rdata);
            rd_stb <= 1'b1;
            @(posedge xclk);
            rd_stb <= 1'b0;
        end
        @(posedge xclk);
        check_flag("rdy after last read", 1'b0, rdy);
    endtask

    task automatic run_row(int r);
        int  len, t_ts, t_prev, bad;
        bit  ok;
        len = sample_len(hbs[r], stalls[r]);
        bad = 0;
        if (pers[r] == 0) begin                 // idle after reset
            for (int i = 0; i < 200; i++) begin
                @(posedge xclk);
                if (!spi_pins.scl || !spi_pins.sda || spi_pins.scl_en ||
                    spi_pins.sda_en || spi_pins.mosi || ts || rdy) bad++;
            end
            check_count("idle cycles with activity", 0, bad);
        end else if (counts[r] == 0) begin      // disable with rdy high, then mid-sample
            write_timing(hbs[r], stalls[r]);
            load_list();
            write_period(pers[r]);
            wait_ts(len + pers[r], t_ts, ok);
            wait_rdy(2 * len, ok);              // first sample stays unread
            write_period(0);
            repeat (5) @(posedge xclk);
            check_flag("rdy after disable", 1'b0, rdy);
            write_period(pers[r]);
            wait_ts(len + pers[r], t_ts, ok);
            repeat (300) @(posedge xclk);
            check_flag("scl_en in transfer", 1'b1, spi_pins.scl_en);
            write_period(0);
            repeat (5) @(posedge xclk);
            check_flag("scl after disable", 1'b1, spi_pins.scl);
            check_flag("sda after disable", 1'b1, spi_pins.sda);
            check_flag("scl_en after disable", 1'b0, spi_pins.scl_en);
            check_flag("sda_en after disable", 1'b0, spi_pins.sda_en);
            ts_count = 0;
            repeat (pers[r] + 200) @(posedge xclk);
            check_count("ts pulses after disable", 0, ts_count);
        end else begin
            write_timing(hbs[r], stalls[r]);
            mon_hb = hbs[r];
            mon_st = stalls[r];
            load_list();
            ts_count = 0;
            mon_on = 1'b1;
            write_period(pers[r]);
            t_prev = 0;
            ok = 1'b1;
            for (int k = 0; k < counts[r] && ok; k++) begin
                wait_ts(len + pers[r] + 100, t_ts, ok);
                if (ok && k > 0) check_count("ts spacing", pers[r], t_ts - t_prev);
                t_prev = t_ts;
                if (ok) wait_rdy(2 * len, ok);
                if (ok) begin
                    check_count("scl rises per sample", rises_per_sample, sample_rises);
                    read_buffer();
                    if (k < counts[r] - 1) load_list();  // next sample uses a new list
                end
            end
            if (ok && pers[r] == 1) begin
                repeat (len + 100) @(posedge xclk);
                check_count("ts pulses in single mode", 1, ts_count);
            end
        end
        mon_on = 1'b0;
        row_err += mon_err;
    endtask

    initial begin
        void'($urandom(32'h9c9e));
        host_wr = '0;
        rd_stb  = 1'b0;
        for (int r = 0; r < n_rows; r++) begin
            limit += 2 * ((counts[r] + 1) * (sample_len(hbs[r], stalls[r]) + pers[r]));
        end
        limit += 1000;                          // reset and list loads
        wait (!imu_ready_reset);
        @(posedge xclk);
        for (int r = 0; r < n_rows; r++) begin
            cur_name = names[r];
            row_err = 0;
            mon_err = 0;
            run_row(r);
            write_period(0);                    // park the dut between rows
            repeat (8) @(posedge xclk);
            if (row_err == 0) begin
                $display("pass %s", cur_name);
            end else begin
                $display("Fail %s: %0d errors", cur_name, row_err);
                n_fail++;
            end
        end
        $display("tests run %0d, failed %0d", n_rows, n_fail);
        if (n_fail == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/imu_bit_timer.sv
`timescale 1ns/1ps

module imu_bit_timer (
    input  logic                     xclk,
    input  logic                     imu_ready_reset,
    input  imu_host_pkg::host_wr_t   host_wr,
    output imu_host_pkg::bit_phase_t phase
);

    imu_host_pkg::half_bit_t half_bit;  // programmed half-bit length
    imu_host_pkg::half_bit_t div_cnt;   // reloading down-counter
    logic                    reload;    // counter at its reload point

    assign reload = (div_cnt == '0);    // zero length reloads every cycle

    always_ff @(posedge xclk) begin
        if (imu_ready_reset) begin
            half_bit <= '0;
            div_cnt  <= '0;
            phase    <= '0;
        end else begin
            if (host_wr.we_timing) begin
                half_bit <= host_wr.data[imu_host_pkg::half_bit_lsb +: 8];
            end
            if (reload) begin
                div_cnt <= half_bit;            // next half-bit starts
            end else begin
                div_cnt <= div_cnt - 1'b1;
            end
            phase <= {phase[2:0], reload};      // ph0 then ph1..ph3 on following cycles
        end
    end

endmodule

//--- rtl/imu_host_pkg.sv
package imu_host_pkg;

    typedef logic [7:0]  half_bit_t;    // half-bit length, xclk cycles minus one
    typedef logic [7:0]  stall_t;       // inter-word stall in half-bits
    typedef logic [31:0] period_t;      // 0 off, 1 single shot, else cycles between starts
    typedef logic [3:0]  bit_phase_t;   // ph0..ph3 strobes, bit n is phn

    localparam int half_bit_lsb = 0;    // timing word: half-bit length field
    localparam int stall_lsb    = 8;    // timing word: stall field
    localparam int reg_num_lsb  = 0;    // list word: register number field
    localparam int wr_delay     = 2;    // period write to enabled level, cycles

    typedef struct packed {
        logic                     we_list;    // write one register list entry
        logic                     we_timing;  // write half-bit length and stall
        logic                     we_period;  // write sample period
        imu_link_pkg::list_addr_t addr;       // list entry for we_list
        logic [31:0]              data;       // payload for any write
    } host_wr_t;

    typedef struct packed {
        logic enabled;  // level, period is nonzero
        logic start;    // one cycle, sample begins
    } trig_t;

    typedef struct packed {
        logic mosi;     // command bit to imu
        logic sda;      // frame select line
        logic sda_en;   // drive enable for sda
        logic scl;      // serial clock
        logic scl_en;   // drive enable for scl
    } spi_pins_t;

endpackage

//--- rtl/imu_link_pkg.sv
package imu_link_pkg;

    typedef logic [15:0] spi_word_t;    // one spi word on mosi or miso
    typedef logic [5:0]  reg_num_t;     // imu register number
    typedef logic [4:0]  list_addr_t;   // register list / reply buffer index

    localparam int spi_word_bits    = 16;   // bits per spi word
    localparam int words_per_sample = 28;   // commands sent and replies kept per sample
    localparam int list_depth       = 32;   // entries in register list and buffer
    localparam int prepare_count    = 3;    // half-bits of prepare before transfer

    // transfer length in half-bits, one extra word flushes the last reply
    localparam int xfer_half_bits = 2 * spi_word_bits * (words_per_sample + 1);

    localparam int last_word_addr = words_per_sample - 1;  // last valid reply index

    localparam spi_word_t prepare_word = 16'h7fff;  // mosi pattern during prepare

    typedef enum logic [1:0] {
        idle,       // waiting for a sample start
        prepare,    // sda pulse, mosi parked high
        transfer,   // 29 words on scl/mosi/miso
        finish      // closing sda pulse
    } seq_state_t;

endpackage

//--- rtl/imu_sample_buffer.sv
`timescale 1ns/1ps

module imu_sample_buffer (
    input  logic                     xclk,
    input  logic                     imu_ready_reset,
    input  imu_host_pkg::bit_phase_t phase,
    input  imu_host_pkg::trig_t      trig,
    input  logic                     miso,
    input  logic                     capture,
    input  logic                     store,
    input  logic                     last_store,
    input  logic                     rd_stb,
    output logic                     rdy,
    output imu_link_pkg::spi_word_t  rdata
);

    logic                     miso_s;     // miso sampled once per half-bit
    imu_link_pkg::spi_word_t  cap_word;   // reply being shifted in, msb first
    imu_link_pkg::spi_word_t  buf_mem [imu_link_pkg::list_depth];  // replies of one sample
    imu_link_pkg::list_addr_t wr_idx;     // next buffer slot to write
    imu_link_pkg::list_addr_t rd_addr;    // host read pointer
    logic                     rd_last;    // host takes the final reply

    assign rd_last = rd_stb && (rd_addr == 5'(imu_link_pkg::last_word_addr));

    always_ff @(posedge xclk) begin
        if (phase[1]) miso_s <= miso;   // ph1 sits inside the scl high half
        if (capture)  cap_word <= {cap_word[imu_link_pkg::spi_word_bits-2:0], miso_s};
        if (store)    buf_mem[wr_idx] <= cap_word;
    end

    always_ff @(posedge xclk) begin
        if (imu_ready_reset || !trig.enabled) begin
            wr_idx  <= '0;
            rd_addr <= '0;
            rdy     <= 1'b0;
        end else begin
            if (trig.start)  wr_idx <= '0;                  // new sample fills from slot 0
            else if (store)  wr_idx <= wr_idx + 1'b1;

            if (trig.start)  rd_addr <= '0;
            else if (rd_stb) rd_addr <= rd_addr + 1'b1;

            if (trig.start || rd_last) rdy <= 1'b0;         // start wins over a late store
            else if (last_store)       rdy <= 1'b1;
        end
    end

    assign rdata = buf_mem[rd_addr];    // follows the read pointer

endmodule

//--- rtl/imu_sample_trigger.sv
`timescale 1ns/1ps

module imu_sample_trigger (
    input  logic                     xclk,
    input  logic                     imu_ready_reset,
    input  imu_host_pkg::host_wr_t   host_wr,
    input  imu_host_pkg::bit_phase_t phase,
    output imu_host_pkg::trig_t      trig
);

    imu_host_pkg::period_t            period;       // last written period
    imu_host_pkg::period_t            period_cnt;   // cycles left to the next start
    logic [imu_host_pkg::wr_delay-1:0] wr_dly;      // period write delay line
    logic                             enabled;      // period nonzero, delayed
    logic                             pending;      // first start not yet issued
    logic                             start;        // registered start pulse
    logic                             fire_first;   // first start of a new period
    logic                             fire_periodic; // repeat start from the counter

    // first start waits for a ph2 slot so the sample lines up with the bit grid
    assign fire_first    = enabled && pending && phase[2];
    // repeats run on raw cycles, only while period is above 1
    assign fire_periodic = enabled && !pending && (period > 32'd1) && (period_cnt == 32'd1);

    always_ff @(posedge xclk) begin
        if (imu_ready_reset) begin
            period     <= '0;
            period_cnt <= '0;
            wr_dly     <= '0;
            enabled    <= 1'b0;
            pending    <= 1'b0;
            start      <= 1'b0;
        end else begin
            if (host_wr.we_period) period <= host_wr.data;
            wr_dly <= {wr_dly[imu_host_pkg::wr_delay-2:0], host_wr.we_period};

            if (wr_dly[imu_host_pkg::wr_delay-1]) begin
                enabled <= (period != '0);      // enabled follows the new period
                pending <= (period != '0);      // rearm first start on every write
            end else if (fire_first) begin
                pending <= 1'b0;
            end

            start <= fire_first || fire_periodic;

            if (fire_first || fire_periodic) begin
                period_cnt <= period;           // start of a new period
            end else if (period_cnt != '0) begin
                period_cnt <= period_cnt - 1'b1;    // parks at 0 in single mode
            end
        end
    end

    assign trig.enabled = enabled;
    assign trig.start   = start;

endmodule

//--- rtl/imu_spi.sv
`timescale 1ns/1ps

module imu_spi (
    input  logic                    xclk,
    input  logic                    imu_ready_reset,
    input  imu_host_pkg::host_wr_t  host_wr,
    input  logic                    miso,
    input  logic                    rd_stb,
    output imu_host_pkg::spi_pins_t spi_pins,
    output logic                    ts,
    output logic                    rdy,
    output imu_link_pkg::spi_word_t rdata
);

    imu_host_pkg::bit_phase_t phase;      // staggered half-bit strobes
    imu_host_pkg::trig_t      trig;       // enabled level and start pulse
    logic                     capture;    // sample miso into the capture register
    logic                     store;      // write captured reply
    logic                     last_store; // final reply of the sample

    imu_bit_timer i_bit_timer (
        .xclk            (xclk),
        .imu_ready_reset (imu_ready_reset),
        .host_wr         (host_wr),
        .phase           (phase)
    );

    imu_sample_trigger i_sample_trigger (
        .xclk            (xclk),
        .imu_ready_reset (imu_ready_reset),
        .host_wr         (host_wr),
        .phase           (phase),
        .trig            (trig)
    );

    imu_spi_sequencer i_spi_sequencer (
        .xclk            (xclk),
        .imu_ready_reset (imu_ready_reset),
        .host_wr         (host_wr),
        .phase           (phase),
        .trig            (trig),
        .spi_pins        (spi_pins),
        .capture         (capture),
        .store           (store),
        .last_store      (last_store)
    );

    imu_sample_buffer i_sample_buffer (
        .xclk            (xclk),
        .imu_ready_reset (imu_ready_reset),
        .phase           (phase),
        .trig            (trig),
        .miso            (miso),
        .capture         (capture),
        .store           (store),
        .last_store      (last_store),
        .rd_stb          (rd_stb),
        .rdy             (rdy),
        .rdata           (rdata)
    );

    always_ff @(posedge xclk) begin
        if (imu_ready_reset) ts <= 1'b0;
        else                 ts <= trig.start;  // one cycle after start, rdy already low
    end

endmodule

//--- rtl/imu_spi_sequencer.sv
`timescale 1ns/1ps

module imu_spi_sequencer (
    input  logic                     xclk,
    input  logic                     imu_ready_reset,
    input  imu_host_pkg::host_wr_t   host_wr,
    input  imu_host_pkg::bit_phase_t phase,
    input  imu_host_pkg::trig_t      trig,
    output imu_host_pkg::spi_pins_t  spi_pins,
    output logic                     capture,
    output logic                     store,
    output logic                     last_store
);

    imu_link_pkg::reg_num_t   list_mem [imu_link_pkg::list_depth];  // registers to read
    imu_host_pkg::stall_t     stall_len;    // programmed stall between words
    imu_link_pkg::seq_state_t state, n_state;
    logic [9:0]               cnt, n_cnt;   // half-bits left in the current state
    logic                     stall, n_stall;   // holding scl high between words
    imu_host_pkg::stall_t     stall_cnt, n_stall_cnt;
    logic                     advance;      // cnt steps to the next transfer half-bit
    imu_link_pkg::list_addr_t ptr;          // next list entry to send
    imu_link_pkg::spi_word_t  cmd;          // command shifter, msb drives mosi
    logic                     scl_q, scl_d; // scl line and its one half-bit delay
    logic                     sda_q, sda_d; // sda line and its one half-bit delay
    logic                     tick;         // half-bit step strobe
    logic                     bit_sample;   // scl high half, miso is valid
    logic                     word_end;     // last bit of a word carrying a reply
    logic                     store_p, last_p;  // store pipeline, waits for the shift

    assign tick       = phase[3];
    assign bit_sample = phase[1] && (state == imu_link_pkg::transfer) && !cnt[0] && !stall;
    // the first word answers nothing, replies start with the second
    assign word_end   = bit_sample && (cnt[4:0] == 5'd0) &&
                        (cnt[9:5] != 5'(imu_link_pkg::words_per_sample));

    always_ff @(posedge xclk) begin
        if (host_wr.we_list) begin
            list_mem[host_wr.addr] <= host_wr.data[imu_host_pkg::reg_num_lsb +: 6];
        end
    end

    always_comb begin
        n_state     = state;
        n_cnt       = cnt;
        n_stall     = stall;
        n_stall_cnt = stall_cnt;
        advance     = 1'b0;
        if (trig.start) begin                   // a start restarts from any state
            n_state     = imu_link_pkg::prepare;
            n_cnt       = 10'(imu_link_pkg::prepare_count - 1);
            n_stall     = 1'b0;
            n_stall_cnt = '0;
        end else if (tick) begin
            case (state)
                imu_link_pkg::prepare: begin
                    if (cnt == 10'd0) begin
                        n_state = imu_link_pkg::transfer;   // first word, no stall
                        n_cnt   = 10'(imu_link_pkg::xfer_half_bits - 1);
                        advance = 1'b1;
                    end else begin
                        n_cnt = cnt - 1'b1;
                    end
                end
                imu_link_pkg::transfer: begin
                    if (stall) begin
                        if (stall_cnt == '0) begin
                            n_stall = 1'b0;             // stall done, next word begins
                            n_cnt   = cnt - 1'b1;
                            advance = 1'b1;
                        end else begin
                            n_stall_cnt = stall_cnt - 1'b1;
                        end
                    end else if (cnt == 10'd0) begin
                        n_state = imu_link_pkg::finish;
                        n_cnt   = 10'd1;                // closing sda pulse then one idle half
                    end else if ((cnt[4:0] == 5'd0) && (stall_len != '0)) begin
                        n_stall     = 1'b1;             // word boundary, hold scl high
                        n_stall_cnt = stall_len - 1'b1;
                    end else begin
                        n_cnt   = cnt - 1'b1;
                        advance = 1'b1;
                    end
                end
                imu_link_pkg::finish: begin
                    if (cnt == 10'd0) n_state = imu_link_pkg::idle;
                    else              n_cnt   = cnt - 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge xclk) begin
        if (imu_ready_reset) begin
            stall_len <= '0;
        end else if (host_wr.we_timing) begin
            stall_len <= host_wr.data[imu_host_pkg::stall_lsb +: 8];
        end
    end

    always_ff @(posedge xclk) begin
        if (imu_ready_reset || !trig.enabled) begin    // disable drops the lines at once
            state      <= imu_link_pkg::idle;
            cnt        <= '0;
            stall      <= 1'b0;
            stall_cnt  <= '0;
            ptr        <= '0;
            cmd        <= '0;
            scl_q      <= 1'b1;
            scl_d      <= 1'b1;
            sda_q      <= 1'b1;
            sda_d      <= 1'b1;
            capture    <= 1'b0;
            store_p    <= 1'b0;
            last_p     <= 1'b0;
            store      <= 1'b0;
            last_store <= 1'b0;
        end else begin
            state     <= n_state;
            cnt       <= n_cnt;
            stall     <= n_stall;
            stall_cnt <= n_stall_cnt;
            // scl low in the first half of every transfer bit
            scl_q <= !((n_state == imu_link_pkg::transfer) && n_cnt[0]);
            // sda low for one half-bit in prepare and in finish
            sda_q <= !(((n_state == imu_link_pkg::prepare) ||
                        (n_state == imu_link_pkg::finish)) && (n_cnt == 10'd1));
            if (tick) begin
                scl_d <= scl_q;
                sda_d <= sda_q;
            end

            if (trig.start) begin
                cmd <= imu_link_pkg::prepare_word;  // mosi high after the first shift
                ptr <= '0;
            end else if (advance && (n_cnt[4:0] == 5'h1f)) begin
                if (n_cnt[9:5] != 5'd0) begin
                    cmd <= {1'b0, list_mem[ptr], 9'b0};  // read command for this entry
                    ptr <= ptr + 1'b1;
                end else begin
                    cmd <= '0;                      // flush word, collects last reply
                end
            end else if ((advance && n_cnt[0]) ||
                         (tick && (state == imu_link_pkg::prepare))) begin
                cmd <= {cmd[14:0], 1'b0};           // next bit on scl falling edge
            end

            capture    <= bit_sample;
            store_p    <= word_end;
            last_p     <= word_end && (cnt[9:5] == 5'd0);
            store      <= store_p;                  // one cycle after the last shift
            last_store <= last_p;
        end
    end

    assign spi_pins.mosi   = cmd[15];
    assign spi_pins.sda    = sda_q;
    assign spi_pins.sda_en = !sda_q || !sda_d;     // low, or one half-bit after rising
    assign spi_pins.scl    = scl_q;
    assign spi_pins.scl_en = !scl_q || !scl_d;

endmodule

//--- sim.f
rtl/imu_link_pkg.sv
rtl/imu_host_pkg.sv
rtl/imu_bit_timer.sv
rtl/imu_sample_trigger.sv
rtl/imu_spi_sequencer.sv
rtl/imu_sample_buffer.sv
rtl/imu_spi.sv
bench/tb_clock.sv
bench/imu_model.sv
bench/tb_imu_spi.sv
